// ==== design/regport_cfg.svh ====
// Shared constants for the register-access subsystem.
// Included by the package and by every module that sizes logic from them.

`ifndef REGPORT_CFG_SVH
`define REGPORT_CFG_SVH

// Register-port widths.
`define RP_AWIDTH 16
`define RP_DWIDTH 32

// Pending cycles the bridge waits for ready before it answers SLVERR.
`define RP_TIMEOUT 64

// Scratch register file depth, indexed by the low address bits.
`define REGFILE_WORDS 16

// Control/status block answers this many cycles after a strobe.
`define CSR_WAIT 3
`define CSR_ID 32'h52500001

`endif

// ==== design/regport_pkg.sv ====
// Types for the register port shared by the bridge, the decoder and the
// register blocks. Referenced by scoped name from each module.

`default_nettype none

`include "regport_cfg.svh"

package regport_pkg;

  // Request from the bridge towards a register block.
  typedef struct packed {
    logic                  rd;     // One-cycle read strobe.
    logic                  wt;     // One-cycle write strobe.
    logic [`RP_AWIDTH-1:0] addr;
    logic [`RP_DWIDTH-1:0] wdata;
  } regport_req_t;

  // Answer from a register block. Ready is high for one cycle.
  typedef struct packed {
    logic [`RP_DWIDTH-1:0] rdata;
    logic                  ready;
  } regport_rsp_t;

  // Target chosen from address bits 15:12.
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_CSR,
    SEL_NONE
  } slave_sel_t;

endpackage

`default_nettype wire

// ==== design/axil_to_regport.sv ====
// AXI4-lite slave that turns single reads and writes into register-port strobes.
// One transaction is in flight at a time and reads win over writes in idle.
// A missing ready ends the access with SLVERR after `RP_TIMEOUT pending cycles.

`timescale 1ns/10ps
`default_nettype none

`include "regport_cfg.svh"

module axil_to_regport (
  input  wire                       s_axi_aclk,
  input  wire                       s_axi_areset,

  input  wire [31:0]                s_axi_awaddr,
  input  wire                       s_axi_awvalid,
  output logic                      s_axi_awready,
  input  wire [31:0]                s_axi_wdata,
  input  wire [3:0]                 s_axi_wstrb,
  input  wire                       s_axi_wvalid,
  output logic                      s_axi_wready,
  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  wire                       s_axi_bready,
  input  wire [31:0]                s_axi_araddr,
  input  wire                       s_axi_arvalid,
  output logic                      s_axi_arready,
  output logic [31:0]               s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  wire                       s_axi_rready,

  output regport_pkg::regport_req_t rp_req,
  input  wire regport_pkg::regport_rsp_t rp_rsp
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         CNT_W       = $clog2(`RP_TIMEOUT);

  typedef enum logic [2:0] {
    IDLE,
    READ_INIT,
    WRITE_INIT,
    READ_PEND,
    WRITE_PEND,
    READ_DONE,
    WRITE_DONE
  } state_t;

  state_t                state;
  logic [CNT_W-1:0]      count;
  logic [1:0]            resp;
  logic                  timeout;
  logic [`RP_AWIDTH-1:0] addr_q;
  logic [`RP_DWIDTH-1:0] rdata_q;

  assign timeout = (count == CNT_W'(`RP_TIMEOUT - 1));

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      state <= IDLE;
      count <= '0;
      resp  <= RESP_OKAY;
    end else begin
      case (state)
        IDLE: begin
          if (s_axi_arvalid) begin
            state <= READ_INIT;
          end else if (s_axi_awvalid) begin
            state <= WRITE_INIT;
          end
        end

        READ_INIT: begin
          state <= READ_PEND;
          count <= '0;
        end

        WRITE_INIT: begin
          if (s_axi_wvalid) begin
            state <= WRITE_PEND;
            count <= '0;
          end
        end

        READ_PEND, WRITE_PEND: begin
          if (rp_rsp.ready || timeout) begin
            state <= (state == READ_PEND) ? READ_DONE : WRITE_DONE;
            resp  <= rp_rsp.ready ? RESP_OKAY : RESP_SLVERR;
          end else begin
            count <= count + 1'b1;
          end
        end

        READ_DONE: begin
          if (s_axi_rready) begin
            state <= IDLE;
          end
        end

        WRITE_DONE: begin
          if (s_axi_bready) begin
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Address and read data.
  always_ff @(posedge s_axi_aclk) begin
    if (state == IDLE) begin
      addr_q <= s_axi_arvalid ? s_axi_araddr[`RP_AWIDTH-1:0] : s_axi_awaddr[`RP_AWIDTH-1:0];
    end
    if (state == READ_PEND) begin
      if (rp_rsp.ready) begin
        rdata_q <= rp_rsp.rdata;
      end else if (timeout) begin
        rdata_q <= '0;  // Timed-out reads return zero.
      end
    end
  end

  assign s_axi_arready = (state == IDLE);
  assign s_axi_awready = (state == IDLE) && !s_axi_arvalid;
  assign s_axi_wready  = (state == WRITE_INIT);

  assign s_axi_rvalid  = (state == READ_DONE);
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = resp;
  assign s_axi_bvalid  = (state == WRITE_DONE);
  assign s_axi_bresp   = resp;

  // Write data goes straight from the W channel, full word only.
  assign rp_req.rd    = (state == READ_INIT);
  assign rp_req.wt    = (state == WRITE_INIT) && s_axi_wvalid;
  assign rp_req.addr  = addr_q;
  assign rp_req.wdata = s_axi_wdata;

endmodule

`default_nettype wire

// ==== design/regport_decoder.sv ====
// Splits the single register port between the scratch register file and the
// control/status block by address bits 15:12. The target is latched on each
// strobe so the later ready is routed back from the same block.

`timescale 1ns/10ps
`default_nettype none

`include "regport_cfg.svh"

module regport_decoder (
  input  wire                            s_axi_aclk,
  input  wire                            s_axi_areset,
  input  wire regport_pkg::regport_req_t req,
  output regport_pkg::regport_rsp_t      rsp,
  output regport_pkg::regport_req_t      regfile_req,
  output regport_pkg::regport_req_t      csr_req,
  input  wire regport_pkg::regport_rsp_t regfile_rsp,
  input  wire regport_pkg::regport_rsp_t csr_rsp
);

  regport_pkg::slave_sel_t addr_sel;
  regport_pkg::slave_sel_t sel_q;
  logic                    strobe;

  always_comb begin
    case (req.addr[`RP_AWIDTH-1 -: 4])
      4'd0:    addr_sel = regport_pkg::SEL_REGFILE;
      4'd1:    addr_sel = regport_pkg::SEL_CSR;
      default: addr_sel = regport_pkg::SEL_NONE;
    endcase
  end

  assign strobe = req.rd | req.wt;

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      sel_q <= regport_pkg::SEL_NONE;
    end else if (strobe) begin
      sel_q <= addr_sel;
    end
  end

  // Address and data reach both blocks, strobes only the selected one.
  always_comb begin
    regfile_req    = req;
    regfile_req.rd = req.rd & (addr_sel == regport_pkg::SEL_REGFILE);
    regfile_req.wt = req.wt & (addr_sel == regport_pkg::SEL_REGFILE);
    csr_req        = req;
    csr_req.rd     = req.rd & (addr_sel == regport_pkg::SEL_CSR);
    csr_req.wt     = req.wt & (addr_sel == regport_pkg::SEL_CSR);
  end

  always_comb begin
    case (sel_q)
      regport_pkg::SEL_REGFILE: rsp = regfile_rsp;
      regport_pkg::SEL_CSR:     rsp = csr_rsp;
      default:                  rsp = '0;  // Unmapped. Bridge times out.
    endcase
  end

endmodule

`default_nettype wire

// ==== design/scratch_regfile.sv ====
// Scratch register file of `REGFILE_WORDS words on the register port.
// Both reads and writes are answered with ready one cycle after the strobe.

`timescale 1ns/10ps
`default_nettype none

`include "regport_cfg.svh"

module scratch_regfile (
  input  wire                            s_axi_aclk,
  input  wire                            s_axi_areset,
  input  wire regport_pkg::regport_req_t req,
  output regport_pkg::regport_rsp_t      rsp
);

  localparam int IDX_W = $clog2(`REGFILE_WORDS);

  logic [`RP_DWIDTH-1:0] mem [`REGFILE_WORDS];
  logic [IDX_W-1:0]      idx;
  logic [`RP_DWIDTH-1:0] rdata_q;
  logic                  ready_q;

  assign idx = req.addr[IDX_W-1:0];

  // Contents start at zero after reset.
  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      for (int i = 0; i < `REGFILE_WORDS; i++) begin
        mem[i] <= '0;
      end
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.rd | req.wt;
      if (req.wt) begin
        mem[idx] <= req.wdata;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (req.rd) begin
      rdata_q <= mem[idx];
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

// ==== design/ctrl_status_regs.sv ====
// Control/status block with the identification word, a control register and
// a count of control writes. Ready follows each strobe after `CSR_WAIT cycles.

`timescale 1ns/10ps
`default_nettype none

`include "regport_cfg.svh"

module ctrl_status_regs (
  input  wire                            s_axi_aclk,
  input  wire                            s_axi_areset,
  input  wire regport_pkg::regport_req_t req,
  output regport_pkg::regport_rsp_t      rsp
);

  localparam int              OFS_W      = `RP_AWIDTH - 4;
  localparam int              WAIT_W     = $clog2(`CSR_WAIT + 1);
  localparam logic [OFS_W-1:0] OFS_ID     = 'd0;
  localparam logic [OFS_W-1:0] OFS_CTRL   = 'd1;
  localparam logic [OFS_W-1:0] OFS_WCOUNT = 'd2;

  logic [OFS_W-1:0]      offset;
  logic [`RP_DWIDTH-1:0] ctrl_q;
  logic [`RP_DWIDTH-1:0] wcount_q;
  logic [`RP_DWIDTH-1:0] rd_mux;
  logic [`RP_DWIDTH-1:0] rdata_q;
  logic [WAIT_W-1:0]     wait_q;

  assign offset = req.addr[OFS_W-1:0];

  always_comb begin
    case (offset)
      OFS_ID:     rd_mux = `CSR_ID;
      OFS_CTRL:   rd_mux = ctrl_q;
      OFS_WCOUNT: rd_mux = wcount_q;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_areset) begin
      ctrl_q   <= '0;
      wcount_q <= '0;
      wait_q   <= '0;
    end else begin
      if (req.rd || req.wt) begin
        wait_q <= WAIT_W'(`CSR_WAIT);
      end else if (wait_q != '0) begin
        wait_q <= wait_q - 1'b1;
      end
      // Only the control register is writable.
      if (req.wt && offset == OFS_CTRL) begin
        ctrl_q   <= req.wdata;
        wcount_q <= wcount_q + 1'b1;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (req.rd) begin
      rdata_q <= rd_mux;  // Sampled at strobe time.
    end
  end

  assign rsp = '{rdata: rdata_q, ready: (wait_q == WAIT_W'(1))};

endmodule

`default_nettype wire

// ==== design/regport_subsys.sv ====
// Register-access subsystem top. An AXI4-lite slave port reaches the scratch
// register file and the control/status block through the address decoder.

`timescale 1ns/10ps
`default_nettype none

module regport_subsys (
  input  wire         s_axi_aclk,
  input  wire         s_axi_areset,

  input  wire  [31:0] s_axi_awaddr,
  input  wire         s_axi_awvalid,
  output logic        s_axi_awready,
  input  wire  [31:0] s_axi_wdata,
  input  wire  [3:0]  s_axi_wstrb,
  input  wire         s_axi_wvalid,
  output logic        s_axi_wready,
  output logic [1:0]  s_axi_bresp,
  output logic        s_axi_bvalid,
  input  wire         s_axi_bready,
  input  wire  [31:0] s_axi_araddr,
  input  wire         s_axi_arvalid,
  output logic        s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  output logic        s_axi_rvalid,
  input  wire         s_axi_rready
);

  regport_pkg::regport_req_t bridge_req;
  regport_pkg::regport_rsp_t bridge_rsp;
  regport_pkg::regport_req_t regfile_req;
  regport_pkg::regport_rsp_t regfile_rsp;
  regport_pkg::regport_req_t csr_req;
  regport_pkg::regport_rsp_t csr_rsp;

  axil_to_regport axil_to_regport_inst (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_areset (s_axi_areset),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .rp_req       (bridge_req),
    .rp_rsp       (bridge_rsp)
  );

  regport_decoder regport_decoder_inst (
    .s_axi_aclk  (s_axi_aclk),
    .s_axi_areset(s_axi_areset),
    .req         (bridge_req),
    .rsp         (bridge_rsp),
    .regfile_req (regfile_req),
    .csr_req     (csr_req),
    .regfile_rsp (regfile_rsp),
    .csr_rsp     (csr_rsp)
  );

  scratch_regfile scratch_regfile_inst (
    .s_axi_aclk  (s_axi_aclk),
    .s_axi_areset(s_axi_areset),
    .req         (regfile_req),
    .rsp         (regfile_rsp)
  );

  ctrl_status_regs ctrl_status_regs_inst (
    .s_axi_aclk  (s_axi_aclk),
    .s_axi_areset(s_axi_areset),
    .req         (csr_req),
    .rsp         (csr_rsp)
  );

endmodule

`default_nettype wire

// ==== verification/regport_subsys_tb.sv ====
// Random-stimulus testbench for the register-access subsystem.
// Drives AXI4-lite reads and writes into the top level and checks every
// response against a register model kept here.

`timescale 1ns/10ps
`default_nettype none

`include "regport_cfg.svh"

module regport_subsys_tb;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int RESET_CYCLES = 3;
  localparam int N_INIT       = `REGFILE_WORDS;
  localparam int N_RANDOM     = 200;
  localparam int N_CSR        = 8;
  localparam int N_MIX        = 61;
  localparam int N_UNMAPPED   = 8;
  localparam int N_TRANS      = N_INIT + N_RANDOM + N_CSR + N_MIX + N_UNMAPPED;
  localparam int MAX_CYCLES   = N_TRANS * (`RP_TIMEOUT + 20) + RESET_CYCLES;

  logic        s_axi_aclk;
  logic        s_axi_areset;
  logic [31:0] s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  logic [31:0] s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;

  // Register model.
  logic [31:0] scratch_model [`REGFILE_WORDS];
  logic [31:0] ctrl_model;
  logic [31:0] wcount_model;
  int          cycle_count = 0;

  regport_subsys regport_subsys_inst (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_areset (s_axi_areset),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata  (s_axi_wdata),
    .s_axi_wstrb  (s_axi_wstrb),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready)
  );

  initial s_axi_aclk = 1'b0;
  always #2 s_axi_aclk = ~s_axi_aclk;  // 4 ns period.

  always @(posedge s_axi_aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // Expected read data and response from the address map.
  function automatic void predict_read(input logic [15:0] addr, output logic [31:0] data,
                                       output logic [1:0] resp);
    resp = RESP_OKAY;
    case (addr[15:12])
      4'd0: data = scratch_model[addr[3:0]];
      4'd1: begin
        case (addr[11:0])
          12'd0:   data = `CSR_ID;
          12'd1:   data = ctrl_model;
          12'd2:   data = wcount_model;
          default: data = '0;
        endcase
      end
      default: begin
        data = '0;
        resp = RESP_SLVERR;
      end
    endcase
  endfunction

  // Applies a write to the model and returns the expected response.
  function automatic logic [1:0] record_write(input logic [15:0] addr,
                                              input logic [31:0] data);
    logic [1:0] resp;
    resp = RESP_OKAY;
    case (addr[15:12])
      4'd0: scratch_model[addr[3:0]] = data;
      4'd1: begin
        if (addr[11:0] == 12'd1) begin
          ctrl_model = data;
          wcount_model++;
        end
      end
      default: resp = RESP_SLVERR;
    endcase
    return resp;
  endfunction

  task automatic write_access(input logic [15:0] addr, input logic [31:0] data);
    logic       aw_done;
    logic       w_done;
    logic [1:0] exp_resp;
    logic [1:0] resp;
    int         delay;
    aw_done  = 1'b0;
    w_done   = 1'b0;
    delay    = $urandom_range(5, 0);
    exp_resp = record_write(addr, data);
    s_axi_awaddr  <= {16'h0, addr};
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= 4'hf;
    s_axi_wvalid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge s_axi_aclk);
      if (!aw_done && s_axi_awready) begin
        aw_done = 1'b1;
        s_axi_awvalid <= 1'b0;
      end
      if (!w_done && s_axi_wready) begin
        w_done = 1'b1;
        s_axi_wvalid <= 1'b0;
      end
    end
    do @(posedge s_axi_aclk); while (!s_axi_bvalid);
    resp = s_axi_bresp;
    repeat (delay) begin
      @(posedge s_axi_aclk);
      compare_value("s_axi_bvalid", s_axi_bvalid, 1'b1);
      compare_value("s_axi_bresp", s_axi_bresp, resp);
    end
    s_axi_bready <= 1'b1;
    @(posedge s_axi_aclk);
    compare_value("s_axi_bvalid", s_axi_bvalid, 1'b1);
    s_axi_bready <= 1'b0;
    compare_value("s_axi_bresp", resp, exp_resp);
    @(posedge s_axi_aclk);
    compare_value("s_axi_bvalid", s_axi_bvalid, 1'b0);  // No second response.
    compare_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
  endtask

  task automatic read_access(input logic [15:0] addr);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic [31:0] data;
    logic [1:0]  resp;
    int          delay;
    delay = $urandom_range(5, 0);
    predict_read(addr, exp_data, exp_resp);
    s_axi_araddr  <= {16'h0, addr};
    s_axi_arvalid <= 1'b1;
    do @(posedge s_axi_aclk); while (!s_axi_arready);
    s_axi_arvalid <= 1'b0;
    do @(posedge s_axi_aclk); while (!s_axi_rvalid);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    // Response must hold while rready is low.
    repeat (delay) begin
      @(posedge s_axi_aclk);
      compare_value("s_axi_rvalid", s_axi_rvalid, 1'b1);
      compare_value("s_axi_rdata", s_axi_rdata, data);
      compare_value("s_axi_rresp", s_axi_rresp, resp);
    end
    s_axi_rready <= 1'b1;
    @(posedge s_axi_aclk);
    compare_value("s_axi_rvalid", s_axi_rvalid, 1'b1);
    s_axi_rready <= 1'b0;
    compare_value("s_axi_rdata", data, exp_data);
    compare_value("s_axi_rresp", resp, exp_resp);
    @(posedge s_axi_aclk);
    compare_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
    compare_value("s_axi_bvalid", s_axi_bvalid, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hca38));
    s_axi_areset  <= 1'b1;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;
    for (int i = 0; i < `REGFILE_WORDS; i++) begin
      scratch_model[i] = '0;
    end
    ctrl_model   = '0;
    wcount_model = '0;
    repeat (RESET_CYCLES) @(posedge s_axi_aclk);
    s_axi_areset <= 1'b0;
    @(posedge s_axi_aclk);
    compare_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
    compare_value("s_axi_bvalid", s_axi_bvalid, 1'b0);

    // Scratch words start at zero.
    for (int i = 0; i < N_INIT; i++) begin
      read_access(16'(i));
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        write_access({4'h0, 12'($urandom)}, $urandom);
      end else begin
        read_access({4'h0, 12'($urandom)});
      end
    end

    // Control/status map.
    read_access(16'h1000);
    write_access(16'h1001, $urandom);
    read_access(16'h1001);
    read_access({4'h1, 12'($urandom_range(12'hfff, 3))});
    write_access(16'h1000, $urandom);  // Identification word is read-only.
    read_access(16'h1000);
    write_access(16'h1002, $urandom);
    read_access(16'h1002);

    // Control writes interleaved with other traffic.
    for (int i = 0; i < N_MIX - 1; i++) begin
      case ($urandom_range(3, 0))
        0:       write_access(16'h1001, $urandom);
        1:       write_access({4'h0, 12'($urandom)}, $urandom);
        2:       read_access({4'h0, 12'($urandom)});
        default: read_access(16'h1002);
      endcase
    end
    read_access(16'h1002);

    // Unmapped accesses time out, mapped ones still work afterwards.
    for (int i = 0; i < N_UNMAPPED / 4; i++) begin
      read_access({4'($urandom_range(15, 2)), 12'($urandom)});
      read_access({4'h0, 12'($urandom)});
      write_access({4'($urandom_range(15, 2)), 12'($urandom)}, $urandom);
      read_access(16'h1002);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/regport_pkg.sv
design/axil_to_regport.sv
design/regport_decoder.sv
design/scratch_regfile.sv
design/ctrl_status_regs.sv
design/regport_subsys.sv
verification/regport_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: regport_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/regport_pkg.sv
      - design/axil_to_regport.sv
      - design/regport_decoder.sv
      - design/scratch_regfile.sv
      - design/ctrl_status_regs.sv
      - design/regport_subsys.sv
      - target: simulation
        files:
          - verification/regport_subsys_tb.sv
